/* rtl/trace_pkg.sv */
// every trace stream carries bytes; the encoder buffer is sized to the largest frame
package trace_pkg;

  // one byte on any trace stream
  typedef logic [7:0] byte_t;

  // interrupt controller fields
  typedef logic [7:0] irq_id_t;
  typedef logic [7:0] prio_t;

  // free-running cycle count that wraps
  typedef logic [31:0] timestamp_t;

  // software trace payload
  typedef logic [31:0] word_t;

  // first byte of each frame tells the host which source sent it
  localparam byte_t TagIrq = 8'h01;
  localparam byte_t TagSw = 8'h02;

  // frame lengths in bytes including the tag
  localparam int IrqFrameLen = 7;
  localparam int SwFrameLen = 5;

  // encoder buffer size
  localparam int MaxFrameLen = IrqFrameLen;

  // byte position inside a frame
  localparam int FrameIdxWidth = $clog2(MaxFrameLen);
  typedef logic [FrameIdxWidth-1:0] frame_idx_t;

endpackage

/* rtl/irq_trace_packer.sv */
// one interrupt frame in flight at a time; the timestamp wraps after 2^32 cycles
module irq_trace_packer (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               irq_valid_i,
  output logic               irq_ready_o,
  input  trace_pkg::irq_id_t irq_id_i,
  input  trace_pkg::prio_t   irq_level_i,
  output trace_pkg::byte_t   out_data_o,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output logic               out_last_o
);
  import trace_pkg::*;

  timestamp_t ts_q;
  logic       busy_q;
  frame_idx_t idx_q;
  // tag, id, level, timestamp; the top element is on the output
  byte_t [IrqFrameLen-1:0] frame_q;

  logic accept;
  logic fire;

  assign irq_ready_o = ~busy_q;
  assign accept = irq_valid_i & irq_ready_o;
  assign fire = out_valid_o & out_ready_i;

  assign out_valid_o = busy_q;
  assign out_data_o = frame_q[IrqFrameLen-1];
  assign out_last_o = (idx_q == frame_idx_t'(IrqFrameLen - 1));

  // cycles since reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ts_q <= '0;
    end else begin
      ts_q <= ts_q + timestamp_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      idx_q <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      idx_q <= '0;
    end else if (fire) begin
      if (out_last_o) begin
        busy_q <= 1'b0;
      end else begin
        idx_q <= idx_q + frame_idx_t'(1);
      end
    end
  end

  // capture uses the counter value on the accepting edge
  always_ff @(posedge clk_i) begin
    if (accept) begin
      frame_q <= {TagIrq, irq_id_i, irq_level_i, ts_q};
    end else if (fire) begin
      frame_q <= {frame_q[IrqFrameLen-2:0], 8'h00};
    end
  end

endmodule

/* rtl/sw_trace_packer.sv */
// one software word in flight at a time; word bytes go out MSB first
module sw_trace_packer (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             sw_valid_i,
  output logic             sw_ready_o,
  input  trace_pkg::word_t sw_data_i,
  output trace_pkg::byte_t out_data_o,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic             out_last_o
);
  import trace_pkg::*;

  logic       busy_q;
  frame_idx_t idx_q;
  // tag then word, shifted up one byte per transfer
  byte_t [SwFrameLen-1:0] frame_q;

  logic accept;
  logic fire;

  assign sw_ready_o = ~busy_q;
  assign accept = sw_valid_i & sw_ready_o;
  assign fire = out_valid_o & out_ready_i;

  assign out_valid_o = busy_q;
  assign out_data_o = frame_q[SwFrameLen-1];
  assign out_last_o = (idx_q == frame_idx_t'(SwFrameLen - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      idx_q <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      idx_q <= '0;
    end else if (fire) begin
      if (out_last_o) begin
        busy_q <= 1'b0;
      end else begin
        idx_q <= idx_q + frame_idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      frame_q <= {TagSw, sw_data_i};
    end else if (fire) begin
      frame_q <= {frame_q[SwFrameLen-2:0], 8'h00};
    end
  end

endmodule

/* rtl/frame_arbiter.sv */
// sources must hold valid from the first byte of a frame to its last; grant switches between frames
module frame_arbiter (
  input  logic             clk_i,
  input  logic             reset_i,
  input  trace_pkg::byte_t a_data_i,
  input  logic             a_valid_i,
  output logic             a_ready_o,
  input  logic             a_last_i,
  input  trace_pkg::byte_t b_data_i,
  input  logic             b_valid_i,
  output logic             b_ready_o,
  input  logic             b_last_i,
  output trace_pkg::byte_t out_data_o,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic             out_last_o
);
  // 0 selects source a, 1 selects source b
  logic busy_q;
  logic grant_q;
  logic prio_q;

  logic pick;
  logic sel;

  // round-robin only matters when both want the path
  always_comb begin
    if (a_valid_i && b_valid_i) begin
      pick = prio_q;
    end else begin
      pick = b_valid_i;
    end
  end

  assign sel = busy_q ? grant_q : pick;

  assign out_valid_o = sel ? b_valid_i : a_valid_i;
  assign out_data_o = sel ? b_data_i : a_data_i;
  assign out_last_o = sel ? b_last_i : a_last_i;

  assign a_ready_o = ~sel & out_ready_i;
  assign b_ready_o = sel & out_ready_i;

  // lock as soon as a byte is offered, so valid and data stay stable
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      grant_q <= 1'b0;
      prio_q <= 1'b0;
    end else if (out_valid_o && out_ready_i && out_last_o) begin
      busy_q <= 1'b0;
      prio_q <= ~sel;
    end else if (out_valid_o) begin
      busy_q <= 1'b1;
      grant_q <= sel;
    end
  end

endmodule

/* rtl/cobs_encoder.sv */
// frames must not exceed MaxFrameLen bytes, so a code byte never reaches FF
module cobs_encoder (
  input  logic             clk_i,
  input  logic             reset_i,
  input  trace_pkg::byte_t in_data_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic             in_last_i,
  output trace_pkg::byte_t out_data_o,
  output logic             out_valid_o,
  input  logic             out_ready_i
);
  import trace_pkg::*;

  localparam int CntWidth = $clog2(MaxFrameLen + 1);

  typedef logic [CntWidth-1:0] cnt_t;

  // emit_q low means collecting
  logic       emit_q;
  logic       first_q;
  frame_idx_t wr_idx_q;
  cnt_t       len_q;
  cnt_t       pos_q;
  byte_t      mem_q [MaxFrameLen];

  cnt_t scan_start;
  cnt_t run_len;
  logic run_stop;
  logic at_end;
  logic at_zero;
  logic in_fire;
  logic out_fire;

  assign in_ready_o = ~emit_q;
  assign in_fire = in_valid_i & in_ready_o;
  assign out_valid_o = emit_q;
  assign out_fire = out_valid_o & out_ready_i;

  assign at_end = (pos_q == len_q);
  assign at_zero = ~at_end && (mem_q[pos_q] == 8'h00);

  // leading code scans from byte 0, a replaced zero scans from the byte after it
  assign scan_start = first_q ? pos_q : pos_q + cnt_t'(1);

  // non-zero run length up to the next zero or the end of the payload
  always_comb begin
    run_len = '0;
    run_stop = 1'b0;
    for (int i = 0; i < MaxFrameLen; i++) begin
      if ((cnt_t'(i) >= scan_start) && !run_stop) begin
        if ((cnt_t'(i) < len_q) && (mem_q[i] != 8'h00)) begin
          run_len = run_len + cnt_t'(1);
        end else begin
          run_stop = 1'b1;
        end
      end
    end
  end

  always_comb begin
    if (first_q || at_zero) begin
      out_data_o = byte_t'(run_len) + byte_t'(1);
    end else if (at_end) begin
      // frame delimiter
      out_data_o = 8'h00;
    end else begin
      out_data_o = mem_q[pos_q];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      emit_q <= 1'b0;
      first_q <= 1'b0;
      wr_idx_q <= '0;
      len_q <= '0;
      pos_q <= '0;
    end else if (in_fire) begin
      if (in_last_i) begin
        emit_q <= 1'b1;
        first_q <= 1'b1;
        wr_idx_q <= '0;
        pos_q <= '0;
        len_q <= cnt_t'(wr_idx_q) + cnt_t'(1);
      end else begin
        wr_idx_q <= wr_idx_q + frame_idx_t'(1);
      end
    end else if (out_fire) begin
      if (first_q) begin
        // leading code does not consume a payload byte
        first_q <= 1'b0;
      end else if (at_end) begin
        emit_q <= 1'b0;
      end else begin
        pos_q <= pos_q + cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      mem_q[wr_idx_q] <= in_data_i;
    end
  end

endmodule

/* rtl/byte_fifo.sv */
// FifoDepth must be 2 or more; when full, a write is taken only together with a read
module byte_fifo #(
  parameter int FifoDepth = 16
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  trace_pkg::byte_t wr_data_i,
  input  logic             wr_valid_i,
  output logic             wr_ready_o,
  output trace_pkg::byte_t rd_data_o,
  output logic             rd_valid_o,
  input  logic             rd_ready_i
);
  import trace_pkg::*;

  localparam int PtrWidth = $clog2(FifoDepth);
  localparam int CntWidth = $clog2(FifoDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;

  byte_t               mem_q [FifoDepth];
  ptr_t                wr_ptr_q;
  ptr_t                rd_ptr_q;
  logic [CntWidth-1:0] count_q;

  logic full;
  logic wr_fire;
  logic rd_fire;

  // wraps at FifoDepth, which need not be a power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == ptr_t'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  assign full = (count_q == CntWidth'(FifoDepth));
  assign rd_valid_o = (count_q != '0);
  assign wr_ready_o = ~full | rd_ready_i;
  assign wr_fire = wr_valid_i & wr_ready_o;
  assign rd_fire = rd_valid_o & rd_ready_i;
  assign rd_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (wr_fire) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (rd_fire) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (wr_fire && !rd_fire) begin
        count_q <= count_q + CntWidth'(1);
      end else if (rd_fire && !wr_fire) begin
        count_q <= count_q - CntWidth'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

endmodule

/* rtl/uart_tx.sv */
// 8N1 only, no parity; ClksPerBit must be 2 or more and a new byte waits for the stop bit
module uart_tx #(
  parameter int ClksPerBit = 868
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  trace_pkg::byte_t data_i,
  input  logic             valid_i,
  output logic             ready_o,
  output logic             tx_o
);
  localparam int CntWidth = $clog2(ClksPerBit);
  localparam int FrameBits = 10;

  logic                 busy_q;
  logic [CntWidth-1:0]  clk_cnt_q;
  logic [3:0]           bit_idx_q;
  // stop, data, start; bit 0 drives the line
  logic [FrameBits-1:0] shift_q;

  logic bit_done;

  assign ready_o = ~busy_q;
  assign tx_o = shift_q[0];
  assign bit_done = (clk_cnt_q == CntWidth'(ClksPerBit - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      // line idles high
      shift_q <= '1;
    end else if (!busy_q) begin
      if (valid_i) begin
        busy_q <= 1'b1;
        clk_cnt_q <= '0;
        bit_idx_q <= '0;
        shift_q <= {1'b1, data_i, 1'b0};
      end
    end else if (bit_done) begin
      clk_cnt_q <= '0;
      // ones shift in behind the stop bit
      shift_q <= {1'b1, shift_q[FrameBits-1:1]};
      if (bit_idx_q == 4'(FrameBits - 1)) begin
        busy_q <= 1'b0;
      end else begin
        bit_idx_q <= bit_idx_q + 4'd1;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + CntWidth'(1);
    end
  end

endmodule

/* rtl/trace_top.sv */
// no byte is dropped under back-pressure; source requests simply wait while their ready is low
module trace_top #(
  parameter int ClksPerBit = 868,
  parameter int FifoDepth = 16
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               irq_valid_i,
  output logic               irq_ready_o,
  input  trace_pkg::irq_id_t irq_id_i,
  input  trace_pkg::prio_t   irq_level_i,
  input  logic               sw_valid_i,
  output logic               sw_ready_o,
  input  trace_pkg::word_t   sw_data_i,
  output logic               tx_o
);
  import trace_pkg::*;

  // packer outputs
  byte_t irq_byte;
  logic  irq_byte_valid;
  logic  irq_byte_ready;
  logic  irq_byte_last;
  byte_t sw_byte;
  logic  sw_byte_valid;
  logic  sw_byte_ready;
  logic  sw_byte_last;

  // shared path
  byte_t arb_byte;
  logic  arb_byte_valid;
  logic  arb_byte_ready;
  logic  arb_byte_last;
  byte_t enc_byte;
  logic  enc_byte_valid;
  logic  enc_byte_ready;
  byte_t fifo_byte;
  logic  fifo_byte_valid;
  logic  uart_ready;

  irq_trace_packer irq_trace_packer_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .irq_valid_i(irq_valid_i),
    .irq_ready_o(irq_ready_o),
    .irq_id_i   (irq_id_i),
    .irq_level_i(irq_level_i),
    .out_data_o (irq_byte),
    .out_valid_o(irq_byte_valid),
    .out_ready_i(irq_byte_ready),
    .out_last_o (irq_byte_last)
  );

  sw_trace_packer sw_trace_packer_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .sw_valid_i (sw_valid_i),
    .sw_ready_o (sw_ready_o),
    .sw_data_i  (sw_data_i),
    .out_data_o (sw_byte),
    .out_valid_o(sw_byte_valid),
    .out_ready_i(sw_byte_ready),
    .out_last_o (sw_byte_last)
  );

  // interrupt frames on port a, software frames on port b
  frame_arbiter frame_arbiter_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .a_data_i   (irq_byte),
    .a_valid_i  (irq_byte_valid),
    .a_ready_o  (irq_byte_ready),
    .a_last_i   (irq_byte_last),
    .b_data_i   (sw_byte),
    .b_valid_i  (sw_byte_valid),
    .b_ready_o  (sw_byte_ready),
    .b_last_i   (sw_byte_last),
    .out_data_o (arb_byte),
    .out_valid_o(arb_byte_valid),
    .out_ready_i(arb_byte_ready),
    .out_last_o (arb_byte_last)
  );

  cobs_encoder cobs_encoder_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_data_i  (arb_byte),
    .in_valid_i (arb_byte_valid),
    .in_ready_o (arb_byte_ready),
    .in_last_i  (arb_byte_last),
    .out_data_o (enc_byte),
    .out_valid_o(enc_byte_valid),
    .out_ready_i(enc_byte_ready)
  );

  byte_fifo #(
    .FifoDepth(FifoDepth)
  ) byte_fifo_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_data_i (enc_byte),
    .wr_valid_i(enc_byte_valid),
    .wr_ready_o(enc_byte_ready),
    .rd_data_o (fifo_byte),
    .rd_valid_o(fifo_byte_valid),
    .rd_ready_i(uart_ready)
  );

  uart_tx #(
    .ClksPerBit(ClksPerBit)
  ) uart_tx_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (fifo_byte),
    .valid_i(fifo_byte_valid),
    .ready_o(uart_ready),
    .tx_o   (tx_o)
  );

endmodule

/* verif/trace_tb.sv */
// ClksPerBit is forced to 4 here; a frame is only checked after its 00 delimiter reaches the line
module trace_tb;
  import trace_pkg::*;

  localparam int ClksPerBit = 4;
  localparam int ClkPeriod = 100;
  localparam int BitTime = ClksPerBit * ClkPeriod;
  localparam int ResetCycles = 5;
  localparam logic [31:0] Seed = 32'haf493b4c;

  localparam int NumIrqFrames = 3;
  localparam int NumPairs = 4;
  localparam int NumBurst = 10;
  // wire bytes of every frame sent, delimiters included
  localparam int ExpectedBytes = (1 + NumPairs + NumBurst) * (SwFrameLen + 2)
                               + (NumIrqFrames + NumPairs) * (IrqFrameLen + 2);
  localparam int TimeoutCycles = ExpectedBytes * 10 * ClksPerBit * 2 + 1000;

  typedef byte_t byte_q_t[$];

  logic    clk_i;
  logic    reset_i;
  logic    irq_valid_i;
  logic    irq_ready_o;
  irq_id_t irq_id_i;
  prio_t   irq_level_i;
  logic    sw_valid_i;
  logic    sw_ready_o;
  word_t   sw_data_i;
  logic    tx_o;

  int         error_count;
  int         cycle_count;
  byte_q_t    rx_q;
  byte_q_t    raw_frame;
  byte_q_t    dec_frame;
  timestamp_t last_ts;
  bit         have_ts;
  bit         sw_ready_low_seen;

  trace_top #(
    .ClksPerBit(ClksPerBit),
    .FifoDepth (16)
  ) trace_top_inst (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .irq_valid_i(irq_valid_i),
    .irq_ready_o(irq_ready_o),
    .irq_id_i   (irq_id_i),
    .irq_level_i(irq_level_i),
    .sw_valid_i (sw_valid_i),
    .sw_ready_o (sw_ready_o),
    .sw_data_i  (sw_data_i),
    .tx_o       (tx_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin : watchdog
    wait (cycle_count >= TimeoutCycles);
    $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("CHECKS FAILED");
    $finish;
  end

  // samples tx_o in the middle of each bit of an 8N1 frame
  initial begin : uart_monitor
    byte_t rx_byte;
    @(negedge reset_i);
    forever begin
      @(negedge tx_o);
      #(BitTime / 2);
      if (tx_o !== 1'b0) begin
        $display("uart line dropped for less than half a bit at %0t", $time);
        error_count++;
      end else begin
        for (int i = 0; i < 8; i++) begin
          #(BitTime);
          rx_byte[i] = tx_o;
        end
        #(BitTime);
        if (tx_o !== 1'b1) begin
          $display("uart stop bit missing at %0t", $time);
          error_count++;
        end
        rx_q.push_back(rx_byte);
      end
    end
  end

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at time %0t: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      $display("error at time %0t: %s is %02h, expected %02h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      $display("error at time %0t: %s is %08h, expected %08h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_len(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      error_count++;
    end
  endtask

  // reference COBS encoding without the trailing delimiter
  function automatic byte_q_t cobs_encode(input byte_q_t payload);
    byte_q_t enc;
    int      code_pos;
    byte_t   code;
    enc.push_back(8'h00);
    code_pos = 0;
    code = 8'h01;
    foreach (payload[i]) begin
      if (payload[i] == 8'h00) begin
        enc[code_pos] = code;
        code_pos = enc.size();
        enc.push_back(8'h00);
        code = 8'h01;
      end else begin
        enc.push_back(payload[i]);
        code = code + 8'h01;
      end
    end
    enc[code_pos] = code;
    return enc;
  endfunction

  function automatic byte_q_t cobs_decode(input byte_q_t raw);
    byte_q_t dec;
    int      i;
    int      code;
    i = 0;
    while (i < raw.size()) begin
      code = int'(raw[i]);
      i++;
      for (int j = 1; j < code; j++) begin
        if (i < raw.size()) begin
          dec.push_back(raw[i]);
        end
        i++;
      end
      // a code below FF stands for a zero, except at the end of the frame
      if (code < 255 && i < raw.size()) begin
        dec.push_back(8'h00);
      end
    end
    return dec;
  endfunction

  function automatic bit has_delim();
    foreach (rx_q[i]) begin
      if (rx_q[i] == 8'h00) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // waits for a whole frame on the line, then splits it off at its 00
  task automatic next_frame();
    byte_t b;
    raw_frame = {};
    while (!has_delim()) begin
      @(posedge clk_i);
      #1;
    end
    b = rx_q.pop_front();
    while (b != 8'h00) begin
      raw_frame.push_back(b);
      b = rx_q.pop_front();
    end
    dec_frame = cobs_decode(raw_frame);
  endtask

  // raises the requested valids and holds each until its handshake
  task automatic push_events(input bit do_irq, input irq_id_t id, input prio_t level,
                             input bit do_sw, input word_t w);
    bit irq_take;
    bit sw_take;
    irq_id_i = id;
    irq_level_i = level;
    irq_valid_i = do_irq;
    sw_data_i = w;
    sw_valid_i = do_sw;
    while (irq_valid_i || sw_valid_i) begin
      irq_take = irq_valid_i && irq_ready_o;
      sw_take = sw_valid_i && sw_ready_o;
      if (sw_valid_i && !sw_ready_o) begin
        sw_ready_low_seen = 1'b1;
      end
      @(posedge clk_i);
      #1;
      if (irq_take) begin
        irq_valid_i = 1'b0;
      end
      if (sw_take) begin
        sw_valid_i = 1'b0;
      end
    end
  endtask

  task automatic check_sw_frame(input word_t exp_word);
    check_len(dec_frame.size(), SwFrameLen, "software frame length");
    if (dec_frame.size() == SwFrameLen) begin
      check_byte(dec_frame[0], TagSw, "software frame tag");
      check_word({dec_frame[1], dec_frame[2], dec_frame[3], dec_frame[4]}, exp_word,
                 "software word");
    end
  endtask

  task automatic check_irq_frame(input irq_id_t id, input prio_t level);
    timestamp_t ts;
    check_len(dec_frame.size(), IrqFrameLen, "interrupt frame length");
    if (dec_frame.size() == IrqFrameLen) begin
      check_byte(dec_frame[0], TagIrq, "interrupt frame tag");
      check_byte(dec_frame[1], id, "interrupt id");
      check_byte(dec_frame[2], level, "interrupt level");
      ts = {dec_frame[3], dec_frame[4], dec_frame[5], dec_frame[6]};
      if (have_ts && ts <= last_ts) begin
        $display("error at time %0t: interrupt timestamp %08h not above previous %08h",
                 $time, ts, last_ts);
        error_count++;
      end
      last_ts = ts;
      have_ts = 1'b1;
    end
  endtask

  // line and readies are checked through reset and just after it
  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (ResetCycles) begin
      @(posedge clk_i);
      #1;
      check_bit(tx_o, 1'b1, "tx_o during reset");
    end
    reset_i = 1'b0;
    check_bit(irq_ready_o, 1'b1, "irq_ready_o after reset");
    check_bit(sw_ready_o, 1'b1, "sw_ready_o after reset");
    repeat (4) begin
      @(posedge clk_i);
      #1;
      check_bit(tx_o, 1'b1, "tx_o after reset");
    end
  endtask

  task automatic test_single_sw();
    word_t   w;
    byte_q_t payload;
    byte_q_t exp_raw;
    w = 32'h0012_0034;
    payload.push_back(TagSw);
    for (int i = 3; i >= 0; i--) begin
      payload.push_back(w[8*i +: 8]);
    end
    exp_raw = cobs_encode(payload);
    push_events(1'b0, '0, '0, 1'b1, w);
    next_frame();
    check_len(raw_frame.size(), exp_raw.size(), "encoded frame length");
    if (raw_frame.size() == exp_raw.size()) begin
      foreach (exp_raw[i]) begin
        check_byte(raw_frame[i], exp_raw[i], $sformatf("wire byte %0d", i));
      end
    end
    check_sw_frame(w);
  endtask

  task automatic test_single_irq();
    irq_id_t ids[NumIrqFrames];
    prio_t   levels[NumIrqFrames];
    ids = '{8'h05, 8'h1f, 8'h00};
    levels = '{8'h03, 8'h00, 8'h07};
    for (int i = 0; i < NumIrqFrames; i++) begin
      push_events(1'b1, ids[i], levels[i], 1'b0, '0);
      next_frame();
      check_irq_frame(ids[i], levels[i]);
    end
  endtask

  task automatic test_simultaneous();
    irq_id_t id;
    prio_t   level;
    word_t   w;
    byte_t   prev_tag;
    int      irq_seen;
    int      sw_seen;
    // the interrupt test sent the last frame before this one
    prev_tag = TagIrq;
    for (int p = 0; p < NumPairs; p++) begin
      id = 8'($urandom());
      level = 8'($urandom());
      w = $urandom();
      irq_seen = 0;
      sw_seen = 0;
      push_events(1'b1, id, level, 1'b1, w);
      repeat (2) begin
        next_frame();
        if (dec_frame.size() == 0) begin
          $display("empty frame received in simultaneous test at %0t", $time);
          error_count++;
        end else begin
          if (prev_tag != 8'h00) begin
            if (dec_frame[0] == prev_tag) begin
              $display("error at time %0t: source %02h sent twice in a row", $time, prev_tag);
              error_count++;
            end
          end
          prev_tag = dec_frame[0];
          if (dec_frame[0] == TagIrq) begin
            irq_seen++;
            check_irq_frame(id, level);
          end else begin
            sw_seen++;
            check_sw_frame(w);
          end
        end
      end
      check_len(irq_seen, 1, "interrupt frames in pair");
      check_len(sw_seen, 1, "software frames in pair");
    end
  endtask

  task automatic test_backpressure();
    word_t words[$];
    for (int i = 0; i < NumBurst; i++) begin
      words.push_back($urandom());
    end
    sw_ready_low_seen = 1'b0;
    foreach (words[i]) begin
      push_events(1'b0, '0, '0, 1'b1, words[i]);
    end
    check_bit(sw_ready_low_seen, 1'b1, "sw_ready_o low during burst");
    foreach (words[i]) begin
      next_frame();
      check_sw_frame(words[i]);
    end
  endtask

  initial begin : main
    logic [31:0] seed_value;
    seed_value = $urandom(Seed);
    clk_i = 1'b0;
    reset_i = 1'b1;
    irq_valid_i = 1'b0;
    irq_id_i = '0;
    irq_level_i = '0;
    sw_valid_i = 1'b0;
    sw_data_i = '0;
    error_count = 0;
    have_ts = 1'b0;
    last_ts = '0;
    apply_reset();
    test_single_sw();
    test_single_irq();
    test_simultaneous();
    test_backpressure();
    repeat (20) begin
      @(posedge clk_i);
      #1;
    end
    if (rx_q.size() != 0) begin
      $display("%0d bytes left over on the line after the last frame", rx_q.size());
      error_count++;
    end
    $display("checks finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
rtl/trace_pkg.sv
rtl/irq_trace_packer.sv
rtl/sw_trace_packer.sv
rtl/frame_arbiter.sv
rtl/cobs_encoder.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/trace_top.sv
verif/trace_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= trace_tb
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
